// ==== hdl/rv_mem_pkg.sv ====
`default_nettype none

package rv_mem_pkg;

  localparam int unsigned XLEN   = 64;
  localparam int unsigned STRB_W = XLEN / 8;

  // load funct3 encodings.
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } load_op_e;

  // store size in bytes.
  typedef enum logic [3:0] {
    SL_BYTE  = 4'd1,
    SL_HALF  = 4'd2,
    SL_WORD  = 4'd4,
    SL_DWORD = 4'd8
  } store_len_e;

  // one-hot writeback source.
  typedef enum logic [3:0] {
    WB_ALU  = 4'b1000,
    WB_LOAD = 4'b0100,
    WB_IMM  = 4'b0010,
    WB_PC   = 4'b0001
  } wb_sel_e;

  typedef struct packed {
    logic [4:0]      index_rd;
    logic [31:0]     instr;
    logic            jump_en;
    logic            branch_en;
    logic            branch_result;
    logic [XLEN-1:0] branch_pc;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] gpr_data2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] snxt_pc;
    logic            load_en;
    logic            store_en;
    store_len_e      store_len;
    load_op_e        load_opcode;
    logic            wb_en;
    wb_sel_e         wb_choose;
    logic            ebreak;
  } exu_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] dnpc;
    logic            jump_en;
    logic            branch_en;
  } redirect_t;

  typedef struct packed {
    logic [4:0]      index_rd;
    logic            wb_en;
    logic [XLEN-1:0] wb_data;
    logic [31:0]     instr;
    logic            ebreak;
  } mem_wb_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wen;
    logic              ren;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== hdl/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access (
  input  wire logic                         load_en,
  input  wire logic                         store_en,
  input  wire logic [rv_mem_pkg::XLEN-1:0]  addr,
  input  wire logic [rv_mem_pkg::XLEN-1:0]  store_data,
  input  wire rv_mem_pkg::store_len_e       store_len,
  input  wire rv_mem_pkg::load_op_e         load_opcode,
  input  wire logic [rv_mem_pkg::XLEN-1:0]  rdata,
  output rv_mem_pkg::dmem_req_t             req,
  output logic [rv_mem_pkg::XLEN-1:0]       load_data
);

  logic [2:0]                       byte_off;
  logic [5:0]                       bit_off;
  logic [rv_mem_pkg::STRB_W-1:0]    strb_base;
  logic [rv_mem_pkg::XLEN-1:0]      rd_shifted;
  logic [rv_mem_pkg::XLEN-1:0]      rd_ext;

  assign byte_off = addr[2:0];
  assign bit_off  = {byte_off, 3'b000};

  // lane mask for the access size, before the offset shift.
  always_comb begin
    case (store_len)
      rv_mem_pkg::SL_BYTE:  strb_base = 8'h01;
      rv_mem_pkg::SL_HALF:  strb_base = 8'h03;
      rv_mem_pkg::SL_WORD:  strb_base = 8'h0f;
      rv_mem_pkg::SL_DWORD: strb_base = 8'hff;
      default:              strb_base = 8'h00;
    endcase
  end

  always_comb begin
    req.addr  = {addr[rv_mem_pkg::XLEN-1:3], 3'b000};
    req.wdata = store_data << bit_off;
    req.wstrb = store_en ? (strb_base << byte_off) : '0;
    req.wen   = store_en;
    req.ren   = load_en;
  end

  // addressed field lands in the low bits.
  assign rd_shifted = rdata >> bit_off;

  always_comb begin
    case (load_opcode)
      rv_mem_pkg::LB: begin
        rd_ext = {{56{rd_shifted[7]}}, rd_shifted[7:0]};
      end
      rv_mem_pkg::LH: begin
        rd_ext = {{48{rd_shifted[15]}}, rd_shifted[15:0]};
      end
      rv_mem_pkg::LW: begin
        rd_ext = {{32{rd_shifted[31]}}, rd_shifted[31:0]};
      end
      rv_mem_pkg::LD: begin
        rd_ext = rd_shifted;
      end
      rv_mem_pkg::LBU: begin
        rd_ext = {56'd0, rd_shifted[7:0]};
      end
      rv_mem_pkg::LHU: begin
        rd_ext = {48'd0, rd_shifted[15:0]};
      end
      rv_mem_pkg::LWU: begin
        rd_ext = {32'd0, rd_shifted[31:0]};
      end
      default: begin
        rd_ext = '0;
      end
    endcase
  end

  // quiet when no load is in flight.
  assign load_data = load_en ? rd_ext : '0;

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  wire logic                         clk,
  input  wire logic                         rstn,
  input  wire rv_mem_pkg::exu_mem_t         exu_in,
  input  wire logic [rv_mem_pkg::XLEN-1:0]  rdata,
  output rv_mem_pkg::redirect_t             redirect,
  output rv_mem_pkg::dmem_req_t             dmem_req,
  output rv_mem_pkg::mem_wb_t               wb_out
);

  logic                         jump_en;
  logic                         branch_taken;
  logic [rv_mem_pkg::XLEN-1:0]  load_data;

  logic [4:0]                   index_rd_q;
  logic                         wb_en_q;
  logic                         ebreak_q;
  logic [31:0]                  instr_q;
  rv_mem_pkg::wb_sel_e          wb_choose_q;
  logic [rv_mem_pkg::XLEN-1:0]  alu_q;
  logic [rv_mem_pkg::XLEN-1:0]  load_q;
  logic [rv_mem_pkg::XLEN-1:0]  imm_q;
  logic [rv_mem_pkg::XLEN-1:0]  snxt_pc_q;
  logic [rv_mem_pkg::XLEN-1:0]  wb_data;

  assign jump_en      = exu_in.jump_en;
  assign branch_taken = exu_in.branch_en & exu_in.branch_result;

  // next pc is valid in the same cycle as the instruction.
  assign redirect.jump_en   = jump_en;
  assign redirect.branch_en = branch_taken;
  assign redirect.dnpc      = ({rv_mem_pkg::XLEN{jump_en}}      & exu_in.alu_result) |
                              ({rv_mem_pkg::XLEN{branch_taken}} & exu_in.branch_pc);

  mem_access u_mem_access (
    .load_en     (exu_in.load_en),
    .store_en    (exu_in.store_en),
    .addr        (exu_in.alu_result),
    .store_data  (exu_in.gpr_data2),
    .store_len   (exu_in.store_len),
    .load_opcode (exu_in.load_opcode),
    .rdata       (rdata),
    .req         (dmem_req),
    .load_data   (load_data)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      index_rd_q  <= '0;
      wb_en_q     <= 1'b0;
      ebreak_q    <= 1'b0;
      instr_q     <= '0;
      wb_choose_q <= rv_mem_pkg::wb_sel_e'(4'b0000);
    end else begin
      index_rd_q  <= exu_in.index_rd;
      wb_en_q     <= exu_in.wb_en;
      ebreak_q    <= exu_in.ebreak;
      instr_q     <= exu_in.instr;
      wb_choose_q <= exu_in.wb_choose;
    end
  end

  always_ff @(posedge clk) begin
    alu_q     <= exu_in.alu_result;
    load_q    <= load_data;
    imm_q     <= exu_in.imm;
    snxt_pc_q <= exu_in.snxt_pc;
  end

  // anything but a single set bit writes back zero.
  always_comb begin
    case (wb_choose_q)
      rv_mem_pkg::WB_ALU:  wb_data = alu_q;
      rv_mem_pkg::WB_LOAD: wb_data = load_q;
      rv_mem_pkg::WB_IMM:  wb_data = imm_q;
      rv_mem_pkg::WB_PC:   wb_data = snxt_pc_q;
      default:             wb_data = '0;
    endcase
  end

  assign wb_out.index_rd = index_rd_q;
  assign wb_out.wb_en    = wb_en_q;
  assign wb_out.wb_data  = wb_data;
  assign wb_out.instr    = instr_q;
  assign wb_out.ebreak   = ebreak_q;

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int unsigned AW = 10
) (
  input  wire logic                         clk,
  input  wire rv_mem_pkg::dmem_req_t        req,
  output logic [rv_mem_pkg::XLEN-1:0]       rdata
);

  localparam int unsigned DEPTH = 2 ** AW;

  logic [rv_mem_pkg::XLEN-1:0] mem [DEPTH];
  logic [AW-1:0]               idx;

  // doubleword index from the byte address.
  assign idx = req.addr[AW+2:3];

  assign rdata = req.ren ? mem[idx] : '0;

  // byte-masked write.
  always_ff @(posedge clk) begin
    if (req.wen) begin
      for (int b = 0; b < rv_mem_pkg::STRB_W; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
  parameter int unsigned DMEM_AW = 10
) (
  input  wire logic                  clk,
  input  wire logic                  rstn,
  input  wire rv_mem_pkg::exu_mem_t  exu_in,
  output rv_mem_pkg::redirect_t      redirect,
  output rv_mem_pkg::mem_wb_t        wb_out
);

  rv_mem_pkg::dmem_req_t        dmem_req;
  logic [rv_mem_pkg::XLEN-1:0]  dmem_rdata;

  mem_stage u_mem_stage (
    .clk      (clk),
    .rstn     (rstn),
    .exu_in   (exu_in),
    .rdata    (dmem_rdata),
    .redirect (redirect),
    .dmem_req (dmem_req),
    .wb_out   (wb_out)
  );

  // read path is combinational, so a load sees last cycle's store.
  data_ram #(
    .AW (DMEM_AW)
  ) u_data_ram (
    .clk   (clk),
    .req   (dmem_req),
    .rdata (dmem_rdata)
  );

endmodule

`default_nettype wire

// ==== dv/mem_subsys_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
  input wire logic                   clk,
  input wire logic                   rstn,
  input wire rv_mem_pkg::exu_mem_t   exu_in,
  input wire rv_mem_pkg::dmem_req_t  dmem_req,
  input wire rv_mem_pkg::mem_wb_t    wb_out
);

  int unsigned fail_cnt = 0;

  a_no_rw_overlap: assert property (@(posedge clk) !(dmem_req.wen && dmem_req.ren))
    else begin
      $error("read and write enables high together");
      fail_cnt++;
    end

  a_write_has_strobe: assert property (@(posedge clk) dmem_req.wen |-> dmem_req.wstrb != '0)
    else begin
      $error("write with empty byte strobe");
      fail_cnt++;
    end

  a_reset_clears_wb: assert property (@(posedge clk) !rstn |=> !wb_out.wb_en && !wb_out.ebreak)
    else begin
      $error("writeback not cleared by reset");
      fail_cnt++;
    end

  // stage register has a fixed latency of one cycle.
  a_wb_en_follows: assert property (@(posedge clk)
    rstn |=> wb_out.wb_en == $past(exu_in.wb_en))
    else begin
      $error("wb_en does not follow the previous input");
      fail_cnt++;
    end

endmodule

bind mem_stage mem_stage_props u_props (
  .clk      (clk),
  .rstn     (rstn),
  .exu_in   (exu_in),
  .dmem_req (dmem_req),
  .wb_out   (wb_out)
);

`default_nettype wire

// ==== dv/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

  localparam int MAX_CYCLES = 2000;
  localparam logic [63:0] WIN_BASE = 64'h200;

  logic                  clk = 1'b0;
  logic                  rstn;
  rv_mem_pkg::exu_mem_t  exu_in;
  rv_mem_pkg::redirect_t redirect;
  rv_mem_pkg::mem_wb_t   wb_out;

  logic [31:0] lfsr_state = 32'h7955_c92d;
  logic [7:0]  ref_mem [64];
  int          cycles = 0;

  mem_subsys_top #(.DMEM_AW(10)) uut (
    .clk      (clk),
    .rstn     (rstn),
    .exu_in   (exu_in),
    .redirect (redirect),
    .wb_out   (wb_out)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests.", MAX_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int load_width(input rv_mem_pkg::load_op_e op);
    case (op)
      rv_mem_pkg::LB, rv_mem_pkg::LBU: return 1;
      rv_mem_pkg::LH, rv_mem_pkg::LHU: return 2;
      rv_mem_pkg::LW, rv_mem_pkg::LWU: return 4;
      default: return 8;
    endcase
  endfunction

  // gather the bytes little-endian, then extend from the top byte.
  function automatic logic [63:0] model_load(input logic [63:0] addr,
                                             input rv_mem_pkg::load_op_e op);
    int          nbytes;
    logic        is_signed;
    logic [63:0] val;
    nbytes = load_width(op);
    is_signed = (op == rv_mem_pkg::LB) || (op == rv_mem_pkg::LH) || (op == rv_mem_pkg::LW);
    val = '0;
    for (int i = nbytes - 1; i >= 0; i--) begin
      val = {val[55:0], ref_mem[addr - WIN_BASE + i]};
    end
    if (is_signed && val[8*nbytes-1]) begin
      for (int i = 8 * nbytes; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  function automatic rv_mem_pkg::exu_mem_t idle_instr();
    rv_mem_pkg::exu_mem_t t;
    t = '0;
    t.store_len   = rv_mem_pkg::SL_BYTE;
    t.load_opcode = rv_mem_pkg::LB;
    t.wb_choose   = rv_mem_pkg::wb_sel_e'(4'b0000);
    return t;
  endfunction

  // drive one instruction, check redirect now and writeback one edge later.
  task automatic run_instr(input rv_mem_pkg::exu_mem_t ins);
    logic [63:0] exp_data;
    logic [63:0] exp_dnpc;
    logic        taken;
    taken = ins.branch_en & ins.branch_result;
    exp_dnpc = '0;
    if (ins.jump_en) exp_dnpc = ins.alu_result;
    else if (taken) exp_dnpc = ins.branch_pc;
    case (ins.wb_choose)
      rv_mem_pkg::WB_ALU:  exp_data = ins.alu_result;
      rv_mem_pkg::WB_LOAD: exp_data = model_load(ins.alu_result, ins.load_opcode);
      rv_mem_pkg::WB_IMM:  exp_data = ins.imm;
      rv_mem_pkg::WB_PC:   exp_data = ins.snxt_pc;
      default:             exp_data = '0;
    endcase
    if (ins.store_en) begin
      for (int i = 0; i < int'(ins.store_len); i++) begin
        ref_mem[ins.alu_result - WIN_BASE + i] = ins.gpr_data2[8*i +: 8];
      end
    end
    exu_in = ins;
    #1;
    check_val("redirect.dnpc", redirect.dnpc, exp_dnpc);
    check_val("redirect.jump_en", redirect.jump_en, ins.jump_en);
    check_val("redirect.branch_en", redirect.branch_en, taken);
    @(negedge clk);
    check_val("wb_out.wb_en", wb_out.wb_en, ins.wb_en);
    check_val("wb_out.wb_data", wb_out.wb_data, exp_data);
    check_val("wb_out.index_rd", wb_out.index_rd, ins.index_rd);
    check_val("wb_out.instr", wb_out.instr, ins.instr);
    check_val("wb_out.ebreak", wb_out.ebreak, ins.ebreak);
  endtask

  task automatic do_store(input logic [63:0] addr, input int len, input logic [63:0] data);
    rv_mem_pkg::exu_mem_t ins;
    ins = idle_instr();
    ins.store_en   = 1'b1;
    ins.alu_result = addr;
    ins.store_len  = rv_mem_pkg::store_len_e'(len);
    ins.gpr_data2  = data;
    ins.instr      = 32'(rand_bits(32));
    run_instr(ins);
  endtask

  task automatic do_load(input logic [63:0] addr, input rv_mem_pkg::load_op_e op);
    rv_mem_pkg::exu_mem_t ins;
    ins = idle_instr();
    ins.load_en     = 1'b1;
    ins.wb_en       = 1'b1;
    ins.wb_choose   = rv_mem_pkg::WB_LOAD;
    ins.alu_result  = addr;
    ins.load_opcode = op;
    ins.index_rd    = 5'(rand_bits(5));
    ins.instr       = 32'(rand_bits(32));
    run_instr(ins);
  endtask

  task automatic test_wb_select();
    rv_mem_pkg::exu_mem_t ins;
    logic [3:0]           sels [5] = '{4'b1000, 4'b0010, 4'b0001, 4'b1010, 4'b0000};
    for (int k = 0; k < 5; k++) begin
      ins = idle_instr();
      ins.wb_en      = 1'b1;
      ins.wb_choose  = rv_mem_pkg::wb_sel_e'(sels[k]);
      ins.alu_result = rand_bits(64);
      ins.imm        = rand_bits(64);
      ins.snxt_pc    = rand_bits(64);
      ins.index_rd   = 5'(rand_bits(5));
      ins.instr      = 32'(rand_bits(32));
      ins.ebreak     = (k == 2);
      run_instr(ins);
    end
  endtask

  task automatic test_redirect();
    rv_mem_pkg::exu_mem_t ins;
    for (int k = 0; k < 4; k++) begin
      ins = idle_instr();
      ins.alu_result    = rand_bits(64);
      ins.branch_pc     = rand_bits(64);
      ins.jump_en       = (k == 0);
      ins.branch_en     = (k == 1) || (k == 2);
      ins.branch_result = (k == 1);
      ins.wb_en         = 1'b1;
      ins.wb_choose     = (k == 0) ? rv_mem_pkg::WB_PC : rv_mem_pkg::WB_ALU;
      run_instr(ins);
    end
  endtask

  task automatic test_widths();
    logic [63:0] dw_addr;
    int          len;
    int          lw;
    // fill the window first so no load sees uninitialized bytes.
    for (int d = 0; d < 8; d++) begin
      do_store(WIN_BASE + 8 * d, 8, rand_bits(64));
    end
    for (int li = 0; li < 4; li++) begin
      len = 1 << li;
      for (int off = 0; off < 8; off += len) begin
        dw_addr = WIN_BASE + 8 * rand_bits(3);
        do_store(dw_addr + off, len, rand_bits(64));
        for (int op = 0; op < 7; op++) begin
          lw = load_width(rv_mem_pkg::load_op_e'(op));
          do_load(dw_addr + (off & ~(lw - 1)), rv_mem_pkg::load_op_e'(op));
        end
      end
    end
  endtask

  task automatic test_random_traffic();
    logic [63:0] dw_addr;
    int          len;
    int          op;
    for (int n = 0; n < 200; n++) begin
      dw_addr = WIN_BASE + 8 * rand_bits(3);
      if (rand_bits(1)) begin
        len = 1 << rand_bits(2);
        do_store(dw_addr + (rand_bits(3) & ~(len - 1)), len, rand_bits(64));
      end else begin
        op = int'(rand_bits(3));
        if (op == 7) op = 3;
        len = load_width(rv_mem_pkg::load_op_e'(op));
        do_load(dw_addr + (rand_bits(3) & ~(len - 1)), rv_mem_pkg::load_op_e'(op));
      end
    end
  endtask

  initial begin
    // enables stay high through reset so only rstn can clear the stage.
    exu_in        = idle_instr();
    exu_in.wb_en  = 1'b1;
    exu_in.ebreak = 1'b1;
    rstn = 1'b0;
    repeat (10) @(negedge clk);
    check_val("wb_out.wb_en", wb_out.wb_en, 1'b0);
    check_val("wb_out.ebreak", wb_out.ebreak, 1'b0);
    rstn = 1'b1;
    run_instr(idle_instr());
    test_wb_select();
    test_redirect();
    test_widths();
    test_random_traffic();
    if (uut.u_mem_stage.u_props.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/rv_mem_pkg.sv
hdl/mem_access.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_props.sv
dv/mem_subsys_tb.sv
